/* Makefile */
SIM = obj_dir/Vtb_tx_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f sources.f --top-module tb_tx_top -Mdir obj_dir

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

/* common/tx_pkg.sv */
// Shared widths, configuration words and control bundle for the TX slice

package tx_pkg;

    localparam int word_width = 16;  // Parallel word from the PRBS source
    localparam int lane_count = 4;   // Quarter-rate lanes, also bits per quarter

    // Register file addresses
    localparam logic cfg_addr_pi  = 1'b0;  // Interpolator setting
    localparam logic cfg_addr_buf = 1'b1;  // Output buffer setting

    // Interpolator view of a config word
    typedef struct packed {
        logic [12:0] rsvd;
        logic        pi_hold;  // Freeze code updates
        logic [1:0]  pi_code;  // Delay in bit periods
    } pi_cfg_t;

    // Buffer view of the same word
    typedef struct packed {
        logic [10:0] rsvd;
        logic [2:0]  drive;       // Active slices, saturates at four
        logic        buf_invert;  // Swap the legs
        logic        buf_en;
    } buf_cfg_t;

    // One write word, decoded by cfg_addr
    typedef union packed {
        pi_cfg_t  pi;
        buf_cfg_t drv;
    } cfg_word_u;

    // Strobes and settings from tx_ctrl to the datapath
    typedef struct packed {
        logic       word_load;     // New word enters the lanes
        logic       quarter_load;  // 4:1 stage reload
        logic [1:0] lane_sel;      // Which quarter of the word
        logic [1:0] pi_code;       // Applied phase step
        logic       buf_en;
        logic       buf_invert;
        logic [2:0] drive;
    } tx_ctrl_t;

endpackage

/* rtl/output_driver.sv */
`timescale 1ns/1ns

// Differential output stage with slice enables

module output_driver import tx_pkg::*; (
    input  logic       mdll_clk,
    input  logic       rst_n,
    input  tx_ctrl_t   ctl,
    input  logic       ser_dly,
    output logic       dout_p,
    output logic       dout_n,
    output logic [3:0] drive_slice  // One bit per driver slice
);

    logic [3:0] slice_dec;  // Thermometer from the drive count
    logic       data_pol;   // Bit after polarity

    always_comb begin
        case (ctl.drive)
            3'd0:    slice_dec = 4'b0000;
            3'd1:    slice_dec = 4'b0001;
            3'd2:    slice_dec = 4'b0011;
            3'd3:    slice_dec = 4'b0111;
            default: slice_dec = 4'b1111;  // Four and up
        endcase
    end

    assign data_pol = ser_dly ^ ctl.buf_invert;

    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            dout_p      <= 1'b0;
            dout_n      <= 1'b0;
            drive_slice <= '0;
        end else if (!ctl.buf_en) begin
            dout_p      <= 1'b0;  // Both legs parked low
            dout_n      <= 1'b0;
            drive_slice <= '0;
        end else begin
            dout_p      <= data_pol;
            dout_n      <= ~data_pol;
            drive_slice <= slice_dec;
        end
    end

endmodule

/* rtl/phase_shifter.sv */
`timescale 1ns/1ns

// Coarse stand-in for the interpolator phase step
// Delays the serial stream by pi_code whole bit periods

module phase_shifter import tx_pkg::*; #(
    parameter int max_delay = 3  // Deepest tap
) (
    input  logic     mdll_clk,
    input  logic     rst_n,
    input  tx_ctrl_t ctl,
    input  logic     ser_bit,
    output logic     ser_dly
);

    logic [max_delay:0] dly_q;  // Tap i is i + 1 cycles behind ser_bit
    int                 tap;

    // Codes past the last tap stick at the deepest one
    always_comb begin
        if (ctl.pi_code > max_delay) begin
            tap = max_delay;
        end else begin
            tap = ctl.pi_code;
        end
    end

    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            dly_q <= '0;
        end else begin
            dly_q[0] <= ser_bit;
            for (int i = 1; i <= max_delay; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    // Code moves only between words, see tx_ctrl
    // so a step up repeats a bit in the gap and never splits a word
    assign ser_dly = dly_q[tap];

endmodule

/* rtl/tx_ctrl.sv */
`timescale 1ns/1ns

// Timing and configuration for the slice
// Every strobe in the datapath is decoded from the one bit counter here

module tx_ctrl import tx_pkg::*; (
    input  logic      mdll_clk,     // Bit-rate clock
    input  logic      rst_n,
    input  logic      cfg_wr,       // Single-cycle write strobe
    input  logic      cfg_addr,
    input  cfg_word_u cfg_data,
    output logic      clk_prbsgen,  // Word request to the PRBS source
    output tx_ctrl_t  ctl
);

    logic [3:0] bit_cnt;    // Bit position within the word
    pi_cfg_t    pi_reg;     // Last interpolator write
    buf_cfg_t   buf_reg;    // Last buffer write
    logic [1:0] pi_next;    // Code taken at the word boundary
    logic [1:0] pi_cur;     // Code seen by the phase shifter
    logic [3:0] apply_cnt;  // Counter value where the tap may move

    // Free-running, one word per wrap
    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // Register writes, the address picks the view of the union
    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            pi_reg  <= '0;
            buf_reg <= '0;  // Buffer off, no slices
        end else if (cfg_wr) begin
            if (cfg_addr == cfg_addr_pi) begin
                pi_reg <= cfg_data.pi;
            end
            if (cfg_addr == cfg_addr_buf) begin
                buf_reg <= cfg_data.drv;
            end
        end
    end

    // The first bit of the word loaded at word_load sits in tap 0
    // three cycles later, so the old tap stays selected through
    // cycle 2 + old code and the old word leaves intact
    assign apply_cnt = 4'd2 + {2'b00, pi_cur};

    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            pi_next <= '0;
            pi_cur  <= '0;
        end else begin
            if (ctl.word_load && !pi_reg.pi_hold) begin
                pi_next <= pi_reg.pi_code;  // Pending code waits while held
            end
            if (bit_cnt == apply_cnt) begin
                pi_cur <= pi_next;
            end
        end
    end

    assign clk_prbsgen = (bit_cnt == 4'd15);  // Last bit of the current word

    always_comb begin
        ctl.word_load    = (bit_cnt == 4'd0);       // Cycle after the request
        ctl.quarter_load = (bit_cnt[1:0] == 2'd0);  // Every fourth bit
        ctl.lane_sel     = bit_cnt[3:2];
        ctl.pi_code      = pi_cur;
        ctl.buf_en       = buf_reg.buf_en;
        ctl.buf_invert   = buf_reg.buf_invert;
        ctl.drive        = buf_reg.drive;
    end

endmodule

/* rtl/tx_top.sv */
`timescale 1ns/1ns

// 16:1 transmitter slice on the bit-rate clock
// Path is ctl -> 16:4 mux -> 4:1 mux -> phase shifter -> output driver
// din[15] reaches dout_p four edges after the edge that ends the
// clk_prbsgen cycle, plus pi_code, and the rest follow MSB first

module tx_top import tx_pkg::*; #(
    parameter int max_delay = 3  // Phase shifter depth
) (
    input  logic                  mdll_clk,     // Bit-rate clock from the MDLL
    input  logic                  rst_n,
    input  logic [word_width-1:0] din,          // Held from the request to the next one
    input  logic                  cfg_wr,
    input  logic                  cfg_addr,
    input  cfg_word_u             cfg_data,
    output logic                  clk_prbsgen,  // Word request, one pulse per 16 bits
    output logic                  dout_p,
    output logic                  dout_n,
    output logic [3:0]            drive_slice
);

    tx_ctrl_t              ctl;      // Strobes and settings to all stages
    logic [lane_count-1:0] quarter;  // 16:4 to 4:1
    logic                  ser_bit;  // Serial data before the phase step
    logic                  ser_dly;  // Serial data into the driver

    tx_ctrl i_ctrl (
        .mdll_clk    (mdll_clk),
        .rst_n       (rst_n),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .clk_prbsgen (clk_prbsgen),
        .ctl         (ctl)
    );

    hr_16t4_mux i_hr_mux (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .din      (din),
        .ctl      (ctl),
        .quarter  (quarter)
    );

    qr_4t1_mux i_qr_mux (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .ctl      (ctl),
        .quarter  (quarter),
        .ser_bit  (ser_bit)
    );

    phase_shifter #(
        .max_delay (max_delay)
    ) i_phase (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .ctl      (ctl),
        .ser_bit  (ser_bit),
        .ser_dly  (ser_dly)
    );

    output_driver i_drv (
        .mdll_clk    (mdll_clk),
        .rst_n       (rst_n),
        .ctl         (ctl),
        .ser_dly     (ser_dly),
        .dout_p      (dout_p),
        .dout_n      (dout_n),
        .drive_slice (drive_slice)
    );

endmodule

/* serializer/hr_16t4_mux.sv */
`timescale 1ns/1ns

// Half-rate stage, 16 bits in and one 4-bit quarter per four bit times
// Lane k keeps din bits 15-k, 11-k, 7-k, 3-k with the highest at its MSB

module hr_16t4_mux import tx_pkg::*; (
    input  logic                  mdll_clk,
    input  logic                  rst_n,
    input  logic [word_width-1:0] din,      // Sampled at the close of the word_load cycle
    input  tx_ctrl_t              ctl,
    output logic [lane_count-1:0] quarter   // Read by the 4:1 stage on quarter_load
);

    typedef logic [lane_count-1:0][lane_count-1:0] lanes_t;

    lanes_t lane_q;    // Captured lanes
    lanes_t lane_src;  // Lanes as seen this cycle

    // Interleave the word across the lanes
    function automatic lanes_t reorder(input logic [word_width-1:0] w);
        lanes_t l;
        for (int k = 0; k < lane_count; k++) begin
            for (int j = 0; j < lane_count; j++) begin
                l[k][lane_count-1-j] = w[word_width-1-k-lane_count*j];
            end
        end
        return l;
    endfunction

    // One element from each lane, lane 0 lands on the MSB
    function automatic logic [lane_count-1:0] pick(input lanes_t l, input logic [1:0] sel);
        logic [lane_count-1:0] q;
        for (int m = 0; m < lane_count; m++) begin
            q[lane_count-1-m] = l[m][lane_count-1-sel];
        end
        return q;
    endfunction

    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            lane_q <= '0;
        end else if (ctl.word_load) begin
            lane_q <= reorder(din);
        end
    end

    // First quarter goes straight from din in the load cycle
    // so the 4:1 stage picks it up on the same edge as the capture
    assign lane_src = ctl.word_load ? reorder(din) : lane_q;

    // With lane_sel = j this gives din[15-4j] down to din[12-4j]
    assign quarter = pick(lane_src, ctl.lane_sel);

endmodule

/* serializer/qr_4t1_mux.sv */
`timescale 1ns/1ns

// Quarter-rate stage
// Takes a quarter on quarter_load and sends it out MSB first,
// one bit per clock, while the next quarter waits in the 16:4 stage

module qr_4t1_mux import tx_pkg::*; (
    input  logic                  mdll_clk,
    input  logic                  rst_n,
    input  tx_ctrl_t              ctl,
    input  logic [lane_count-1:0] quarter,
    output logic                  ser_bit   // Registered serial stream
);

    logic [lane_count-1:0] shift_q;  // Bits still to go, next one on top

    always_ff @(posedge mdll_clk) begin
        if (!rst_n) begin
            shift_q <= '0;
            ser_bit <= 1'b0;
        end else begin
            ser_bit <= shift_q[lane_count-1];  // Last bit of the old quarter on a reload
            if (ctl.quarter_load) begin
                shift_q <= quarter;
            end else begin
                shift_q <= {shift_q[lane_count-2:0], 1'b0};
            end
        end
    end

endmodule

/* sources.f */
common/tx_pkg.sv
rtl/tx_ctrl.sv
serializer/hr_16t4_mux.sv
serializer/qr_4t1_mux.sv
rtl/phase_shifter.sv
rtl/output_driver.sv
rtl/tx_top.sv
tb/tb_tx_top.sv

/* tb/tb_tx_top.sv */
`timescale 1ns/1ns

module tb_tx_top import tx_pkg::*; ();

    localparam int max_lines = 128;
    localparam int max_cycles = 4096;

    logic                  mdll_clk;
    logic                  rst_n;
    logic [word_width-1:0] din;
    logic                  cfg_wr;
    logic                  cfg_addr;
    cfg_word_u             cfg_data;
    logic                  clk_prbsgen;
    logic                  dout_p;
    logic                  dout_n;
    logic [3:0]            drive_slice;

    // Stimulus table from the data file
    logic [7:0]       op_q     [max_lines];
    logic [8*24-1:0]  name_q   [max_lines];
    logic [15:0]      arg_a    [max_lines];
    logic [15:0]      arg_b    [max_lines];
    int               test_errs[max_lines];
    int               test_done[max_lines];  // Cycle after its last bit
    int               nlines;
    int               slots;                 // Word slots in the whole run
    bit               loaded;

    // Expected serial stream, one entry per falling edge
    bit               exp_valid[max_cycles];
    bit               exp_bit  [max_cycles];
    int               exp_test [max_cycles];

    // Reference model state
    logic [15:0] din_cur;
    logic [1:0]  pi_code_reg;
    bit          pi_hold_reg;
    logic [1:0]  pi_applied;
    bit          buf_en_m;
    bit          buf_inv_m;
    logic [2:0]  drive_m;
    logic [4:0]  pend_buf;   // en, invert, drive waiting to land
    int          pend_cyc;
    logic [31:0] lcg_state;

    int cyc;
    int line_idx;
    int cur_test;
    int fill_left;
    int last_prbs;
    int report_idx;
    int errors;
    int checks;

    tx_top #(
        .max_delay (3)
    ) i_dut (
        .mdll_clk    (mdll_clk),
        .rst_n       (rst_n),
        .din         (din),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .clk_prbsgen (clk_prbsgen),
        .dout_p      (dout_p),
        .dout_n      (dout_n),
        .drive_slice (drive_slice)
    );

    initial begin
        mdll_clk = 1'b0;
        forever #20 mdll_clk = ~mdll_clk;  // 40 ns bit period
    end

    // Filler words, upper half of the state
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Thermometer of enabled slices
    function automatic logic [3:0] slices_for(input logic [2:0] d);
        int n;
        n = (d > 3'd4) ? 4 : int'(d);  // Saturates at four
        return 4'((1 << n) - 1);
    endfunction

    function automatic string test_name(input int id);
        if (id < 0) begin
            return "reset";
        end
        return $sformatf("%0s", name_q[id]);
    endfunction

    task automatic fail_check(input int id);
        errors++;
        if (id >= 0) begin
            test_errs[id]++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  op;
        logic [191:0] nm;
        logic [15:0] a;
        logic [15:0] b;
        fd = $fopen("tb/tx_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/tx_input.txt");
            fail_check(-1);
        end else begin
            while (!$feof(fd) && nlines < max_lines) begin
                line = "";
                code = $fgets(line, fd);
                if (line.len() < 2 || line[0] == "#") begin
                    continue;  // Blank or column notes
                end
                b = '0;
                code = $sscanf(line, "%s %s %h %h", op, nm, a, b);
                if (code >= 3) begin
                    op_q[nlines]  = op;
                    name_q[nlines] = nm;
                    arg_a[nlines] = a;
                    arg_b[nlines] = b;
                    slots += (op == "F") ? int'(a) : 1;
                    nlines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Compares the pins seen at this falling edge with the model
    task automatic check_outputs();
        logic       exp_p;
        logic [3:0] exp_s;
        int         id;
        if (cyc == pend_cyc) begin
            {buf_en_m, buf_inv_m, drive_m} = pend_buf;  // Register write reaches the pins
        end
        id = exp_valid[cyc] ? exp_test[cyc] : cur_test;
        checks++;
        if (!buf_en_m) begin
            if (dout_p !== 1'b0 || dout_n !== 1'b0) begin
                $display("MISMATCH %0s legs expected 00 actual %b%b", test_name(cur_test),
                         dout_p, dout_n);
                fail_check(cur_test);
            end
        end else if (exp_valid[cyc]) begin
            exp_p = exp_bit[cyc] ^ buf_inv_m;
            if (dout_p !== exp_p) begin
                $display("MISMATCH %0s dout_p expected %0b actual %0b", test_name(id),
                         exp_p, dout_p);
                fail_check(id);
            end
            if (dout_n !== ~exp_p) begin  // Complement leg
                $display("MISMATCH %0s dout_n expected %0b actual %0b", test_name(id),
                         ~exp_p, dout_n);
                fail_check(id);
            end
        end
        exp_s = buf_en_m ? slices_for(drive_m) : 4'b0000;
        if (drive_slice !== exp_s) begin
            $display("MISMATCH %0s drive_slice expected %b actual %b", test_name(cur_test),
                     exp_s, drive_slice);
            fail_check(cur_test);
        end
        // Word request spacing
        if (clk_prbsgen === 1'b1) begin
            if (!rst_n || cyc - last_prbs != 16) begin
                $display("clk_prbsgen pulsed after %0d cycles instead of 16", cyc - last_prbs);
                fail_check(cur_test);
            end
            last_prbs = cyc;
        end else if (rst_n && cyc - last_prbs > 16) begin
            $display("clk_prbsgen pulse missing at cycle %0d", cyc);
            fail_check(cur_test);
            last_prbs = cyc;
        end
    endtask

    // One word slot, opened at the falling edge inside the request cycle
    task automatic start_slot();
        int idx;
        if (fill_left == 0) begin
            cur_test = line_idx;
            line_idx++;
            case (op_q[cur_test])
                "C": begin
                    cfg_wr   = 1'b1;
                    cfg_addr = arg_a[cur_test][0];
                    cfg_data = arg_b[cur_test];
                    if (arg_a[cur_test][0] == cfg_addr_pi) begin
                        pi_code_reg = arg_b[cur_test][1:0];
                        pi_hold_reg = arg_b[cur_test][2];
                    end else begin
                        // Pins follow two edges later
                        pend_buf = {arg_b[cur_test][0], arg_b[cur_test][1], arg_b[cur_test][4:2]};
                        pend_cyc = cyc + 2;
                    end
                end
                "W": din_cur = arg_a[cur_test];
                "F": fill_left = int'(arg_a[cur_test]);
                "S": begin
                    checks++;
                    if (drive_slice !== arg_a[cur_test][3:0]) begin
                        $display("MISMATCH %0s drive_slice expected %b actual %b",
                                 test_name(cur_test), arg_a[cur_test][3:0], drive_slice);
                        fail_check(cur_test);
                    end
                end
                default: begin
                    $display("unknown line type in tb/tx_input.txt");
                    fail_check(cur_test);
                end
            endcase
        end
        if (fill_left > 0) begin
            din_cur = lcg_next();
            fill_left--;
        end
        din = din_cur;  // Unchanged word is simply sent again
        if (!pi_hold_reg) begin
            pi_applied = pi_code_reg;  // Taken at this word boundary
        end
        // MSB first, din[15] five edges on plus the phase step
        for (int i = 0; i < 16; i++) begin
            idx = cyc + 5 + int'(pi_applied) + i;
            if (!exp_valid[idx]) begin  // Earlier word keeps its bits on a step down
                exp_valid[idx] = 1'b1;
                exp_bit[idx]   = din_cur[15-i];
                exp_test[idx]  = cur_test;
            end
        end
        test_done[cur_test] = cyc + 24;
    endtask

    task automatic report_ready(input bit flush);
        while (report_idx < line_idx && (flush || test_done[report_idx] <= cyc)) begin
            if (test_errs[report_idx] == 0) begin
                $display("test %0s: ok", test_name(report_idx));
            end else begin
                $display("test %0s: %0d errors", test_name(report_idx), test_errs[report_idx]);
            end
            report_idx++;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        din       = '0;
        cfg_wr    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_data  = '0;
        lcg_state = 32'hdcbb;
        din_cur   = '0;
        {pi_code_reg, pi_hold_reg, pi_applied} = '0;
        {buf_en_m, buf_inv_m, drive_m} = '0;
        pend_buf  = '0;
        pend_cyc  = -1;
        cur_test  = -1;
        last_prbs = 0;
        load_stimulus();
        loaded = 1'b1;
        while (line_idx < nlines || fill_left > 0) begin
            @(negedge mdll_clk);
            cyc++;
            cfg_wr = 1'b0;
            check_outputs();
            report_ready(1'b0);
            if (cyc == 5) begin
                rst_n     = 1'b1;     // Five edges in reset
                last_prbs = cyc - 1;  // Counter is 0 here, first request on 15
            end
            if (rst_n && clk_prbsgen === 1'b1) begin
                start_slot();
            end
        end
        repeat (36) begin  // Drain the last word
            @(negedge mdll_clk);
            cyc++;
            cfg_wr = 1'b0;
            check_outputs();
        end
        report_ready(1'b1);
        $display("tests %0d, checks %0d, errors %0d", nlines, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Run limit from the number of word slots
    initial begin
        wait (loaded);
        #((slots + 4) * 16 * 40);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* tb/tx_input.txt */
# type name arg_a arg_b, args in hex
# C cfg write (addr data), W word (din), F filler (count), S expected drive_slice
C buf_on       1 0011
W word_a5c3    a5c3 0
W word_ffff    ffff 0
W word_0001    0001 0
F filler       8 0
C pi_code1     0 0001
W word_pi1     1234 0
F filler_pi1   2 0
C pi_code2     0 0002
F filler_pi2   3 0
C pi_code3     0 0003
F filler_pi3   3 0
C pi_code0     0 0000
F filler_pi0   2 0
C hold_set     0 0004
C hold_code2   0 0006
F hold_words   2 0
C hold_clear   0 0002
F released     3 0
C invert_on    1 0013
F invert_words 2 0
C buf_off      1 0010
F off_words    2 0
S slice_off    0 0
C drive0       1 0001
S slice_d0     0 0
C drive1       1 0005
S slice_d1     1 0
C drive2       1 0009
S slice_d2     3 0
C drive3       1 000d
S slice_d3     7 0
C drive4       1 0011
S slice_d4     f 0
C drive5       1 0015
S slice_d5     f 0
C drive6       1 0019
S slice_d6     f 0
C drive7       1 001d
S slice_d7     f 0
W word_last    c33c 0
